// File: rename_commit.f
+incdir+logic
logic/rename_pkg.sv
logic/reg_status.sv
logic/reorder_buffer.sv
logic/arch_regfile.sv
logic/operand_select.sv
logic/rename_commit_top.sv
testbench/rename_commit_tb.sv

// File: Bender.yml
package:
  name: rename_commit

sources:
  - include_dirs:
      - logic
    files:
      - logic/rename_pkg.sv
      - logic/reg_status.sv
      - logic/reorder_buffer.sv
      - logic/arch_regfile.sv
      - logic/operand_select.sv
      - logic/rename_commit_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - testbench/rename_commit_tb.sv

// File: testbench/rename_commit_tb.sv
// Testbench for the rename and commit top, applies a stimulus table and checks a behavioral model
`timescale 1ns/1ns
`include "rename_macros.svh"

module rename_commit_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_ROWS     = 32;

    // Issue part, writeback part, flush and the expected issue_ready_o
    typedef struct packed {
        logic                    iv;
        logic [`REG_IDX_LEN-1:0] rd;
        logic [`REG_IDX_LEN-1:0] rs1;
        logic [`REG_IDX_LEN-1:0] rs2;
        logic                    wv;
        logic [`ROB_IDX_LEN-1:0] wtag;
        logic                    fl;
        logic                    rdy;
    } row_t;

    row_t rows[$];
    int   cur_row;

    logic                    clk;
    logic                    rst_n;
    logic                    flush;
    logic                    issue_valid;
    logic [`REG_IDX_LEN-1:0] issue_rd;
    logic [`REG_IDX_LEN-1:0] issue_rs1;
    logic [`REG_IDX_LEN-1:0] issue_rs2;
    logic                    issue_ready;
    logic [`ROB_IDX_LEN-1:0] issue_rob_idx;
    logic                    rs1_ready;
    logic [`XLEN-1:0]        rs1_value;
    logic [`ROB_IDX_LEN-1:0] rs1_tag;
    logic                    rs2_ready;
    logic [`XLEN-1:0]        rs2_value;
    logic [`ROB_IDX_LEN-1:0] rs2_tag;
    logic                    wb_valid;
    logic [`ROB_IDX_LEN-1:0] wb_rob_idx;
    logic [`XLEN-1:0]        wb_value;
    logic                    comm_valid;
    logic [`REG_IDX_LEN-1:0] comm_rd;
    logic [`XLEN-1:0]        comm_value;

    // Reference model state: status table, reorder buffer, register file
    logic                    st_busy  [`REG_NUM];
    logic [`ROB_IDX_LEN-1:0] st_tag   [`REG_NUM];
    logic                    rob_done [`ROB_DEPTH];
    logic [`REG_IDX_LEN-1:0] rob_rd   [`ROB_DEPTH];
    logic [`XLEN-1:0]        rob_val  [`ROB_DEPTH];
    logic [`XLEN-1:0]        rf_val   [`REG_NUM];
    int                      rob_head;
    int                      rob_tail;
    int                      rob_count;

    rename_commit_top DUT (
        .clk_i           (clk),
        .rst_n_i         (rst_n),
        .flush_i         (flush),
        .issue_valid_i   (issue_valid),
        .issue_rd_i      (issue_rd),
        .issue_rs1_i     (issue_rs1),
        .issue_rs2_i     (issue_rs2),
        .issue_ready_o   (issue_ready),
        .issue_rob_idx_o (issue_rob_idx),
        .rs1_ready_o     (rs1_ready),
        .rs1_value_o     (rs1_value),
        .rs1_tag_o       (rs1_tag),
        .rs2_ready_o     (rs2_ready),
        .rs2_value_o     (rs2_value),
        .rs2_tag_o       (rs2_tag),
        .wb_valid_i      (wb_valid),
        .wb_rob_idx_i    (wb_rob_idx),
        .wb_value_i      (wb_value),
        .comm_valid_o    (comm_valid),
        .comm_rd_o       (comm_rd),
        .comm_value_o    (comm_value)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic add_row(input logic iv, input logic [`REG_IDX_LEN-1:0] rd,
                           input logic [`REG_IDX_LEN-1:0] rs1, input logic [`REG_IDX_LEN-1:0] rs2,
                           input logic wv, input logic [`ROB_IDX_LEN-1:0] wtag,
                           input logic fl, input logic rdy);
        rows.push_back({iv, rd, rs1, rs2, wv, wtag, fl, rdy});
    endtask

    task automatic check_value(input string name, input logic [`XLEN-1:0] exp,
                               input logic [`XLEN-1:0] act);
        assert (act === exp) else begin
            $display("error: row %0d %s expected %h actual %h", cur_row, name, exp, act);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // Source rule: register file, then finished buffer entry, else wait on the tag
    task automatic expect_source(input logic [`REG_IDX_LEN-1:0] r, output logic rdy,
                                 output logic [`XLEN-1:0] val, output logic [`ROB_IDX_LEN-1:0] tag);
        if (!st_busy[r]) begin
            rdy = 1'b1;
            val = rf_val[r];
            tag = '0;
        end else if (rob_done[st_tag[r]]) begin
            rdy = 1'b1;
            val = rob_val[st_tag[r]];
            tag = '0;
        end else begin
            rdy = 1'b0;
            val = '0;
            tag = st_tag[r];
        end
    endtask

    task automatic check_outputs(input row_t r);
        logic                    exp_rdy;
        logic [`XLEN-1:0]        exp_val;
        logic [`ROB_IDX_LEN-1:0] exp_tag;
        logic                    exp_cv;
        check_value("issue_ready_o", r.rdy, issue_ready);
        check_value("issue_rob_idx_o", rob_tail, issue_rob_idx);
        expect_source(r.rs1, exp_rdy, exp_val, exp_tag);
        check_value("rs1_ready_o", exp_rdy, rs1_ready);
        check_value("rs1_value_o", exp_val, rs1_value);
        check_value("rs1_tag_o", exp_tag, rs1_tag);
        expect_source(r.rs2, exp_rdy, exp_val, exp_tag);
        check_value("rs2_ready_o", exp_rdy, rs2_ready);
        check_value("rs2_value_o", exp_val, rs2_value);
        check_value("rs2_tag_o", exp_tag, rs2_tag);
        exp_cv = (rob_count != 0) && rob_done[rob_head];
        check_value("comm_valid_o", exp_cv, comm_valid);
        // Head fields only matter while committing
        if (exp_cv) begin
            check_value("comm_rd_o", rob_rd[rob_head], comm_rd);
            check_value("comm_value_o", rob_val[rob_head], comm_value);
        end
    endtask

    // Advance the model by one rising edge
    task automatic update_model(input row_t r, input logic [`XLEN-1:0] wval);
        logic                    acc;
        logic                    cv;
        logic [`REG_IDX_LEN-1:0] crd;
        cv  = (rob_count != 0) && rob_done[rob_head];
        crd = rob_rd[rob_head];
        if (r.fl) begin
            // A head committing in the flush cycle still reaches the register file
            if (cv && (crd != 0)) begin
                rf_val[crd] = rob_val[rob_head];
            end
            for (int i = 0; i < `REG_NUM; i++) begin
                st_busy[i] = 1'b0;
            end
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                rob_done[i] = 1'b0;
            end
            rob_head  = 0;
            rob_tail  = 0;
            rob_count = 0;
        end else begin
            acc = r.iv && (rob_count != `ROB_DEPTH);
            if (cv) begin
                // Last writer frees the register unless an issue claims it now
                if ((st_tag[crd] == rob_head) && !(acc && (r.rd != 0) && (r.rd == crd))) begin
                    st_busy[crd] = 1'b0;
                end
                if (crd != 0) begin
                    rf_val[crd] = rob_val[rob_head];
                end
                rob_head = (rob_head + 1) % `ROB_DEPTH;
                rob_count--;
            end
            if (acc) begin
                if (r.rd != 0) begin
                    st_busy[r.rd] = 1'b1;
                    st_tag[r.rd]  = rob_tail;
                end
                rob_done[rob_tail] = 1'b0;
                rob_rd[rob_tail]   = r.rd;
                rob_val[rob_tail]  = '0;
                rob_tail = (rob_tail + 1) % `ROB_DEPTH;
                rob_count++;
            end
            if (r.wv) begin
                rob_done[r.wtag] = 1'b1;
                rob_val[r.wtag]  = wval;
            end
        end
    endtask

    // Watchdog, sized from the table and reset length
    initial begin
        #((NUM_ROWS + RESET_CYCLES + 20) * CLK_PERIOD);
        $display("Timeout: the stimulus table did not finish in time");
        $display("TEST FAILED");
        $fatal(1);
    end

    initial begin
        logic [`XLEN-1:0] wval;
        void'($urandom(96990));
        clk         = 1'b0;
        rst_n       = 1'b0;
        flush       = 1'b0;
        issue_valid = 1'b0;
        issue_rd    = '0;
        issue_rs1   = '0;
        issue_rs2   = '0;
        wb_valid    = 1'b0;
        wb_rob_idx  = '0;
        wb_value    = '0;
        cur_row     = 0;
        for (int i = 0; i < `REG_NUM; i++) begin
            st_busy[i] = 1'b0;
            st_tag[i]  = '0;
            rf_val[i]  = '0;
        end
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            rob_done[i] = 1'b0;
            rob_rd[i]   = '0;
            rob_val[i]  = '0;
        end
        rob_head  = 0;
        rob_tail  = 0;
        rob_count = 0;

        // Dependency chain, out of order writeback, commit into the register file
        add_row(1, 1, 1, 2, 0, 0, 0, 1);
        add_row(1, 2, 1, 3, 0, 0, 0, 1);
        add_row(1, 3, 2, 1, 1, 1, 0, 1);
        add_row(0, 0, 2, 1, 1, 0, 0, 1);
        add_row(0, 0, 1, 2, 0, 0, 0, 1);
        add_row(0, 0, 1, 2, 0, 0, 0, 1);
        // Later writer of r3 keeps it busy past the earlier commit
        add_row(1, 3, 3, 0, 0, 0, 0, 1);
        add_row(0, 0, 3, 3, 1, 2, 0, 1);
        add_row(0, 0, 3, 3, 0, 0, 0, 1);
        add_row(0, 0, 3, 3, 1, 3, 0, 1);
        // Issue and commit of r3 in one cycle
        add_row(1, 3, 3, 2, 0, 0, 0, 1);
        add_row(0, 0, 3, 3, 1, 4, 0, 1);
        // Destination zero
        add_row(1, 0, 0, 3, 0, 0, 0, 1);
        add_row(0, 0, 0, 3, 1, 5, 0, 1);
        add_row(0, 0, 0, 3, 0, 0, 0, 1);
        add_row(0, 0, 3, 2, 0, 0, 0, 1);
        // Fill the buffer, tags wrap past the last entry
        for (int i = 4; i < 12; i++) begin
            add_row(1, i, i - 1, 1, 0, 0, 0, 1);
        end
        // Ninth issue held until the head commits
        add_row(1, 12, 11, 4, 1, 6, 0, 0);
        add_row(1, 12, 11, 4, 0, 0, 0, 0);
        add_row(1, 12, 11, 4, 0, 0, 0, 1);
        // Flush while full, committed values stay
        // r7 was still in flight before the flush
        add_row(0, 0, 0, 0, 0, 0, 1, 0);
        add_row(1, 5, 3, 7, 0, 0, 0, 1);
        add_row(0, 0, 5, 2, 1, 0, 0, 1);
        add_row(0, 0, 5, 3, 0, 0, 0, 1);
        add_row(0, 0, 5, 0, 0, 0, 0, 1);

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        foreach (rows[i]) begin
            @(negedge clk);
            cur_row     = i;
            wval        = rows[i].wv ? $urandom : '0;
            issue_valid = rows[i].iv;
            issue_rd    = rows[i].rd;
            issue_rs1   = rows[i].rs1;
            issue_rs2   = rows[i].rs2;
            wb_valid    = rows[i].wv;
            wb_rob_idx  = rows[i].wtag;
            wb_value    = wval;
            flush       = rows[i].fl;
            // Combinational outputs settle well before the rising edge
            #(CLK_PERIOD / 4);
            check_outputs(rows[i]);
            update_model(rows[i], wval);
        end

        @(negedge clk);
        issue_valid = 1'b0;
        wb_valid    = 1'b0;
        flush       = 1'b0;
        $display("TEST OK");
        $finish;
    end

endmodule

// File: logic/rename_commit_top.sv
// Rename and commit subsystem top: status table, reorder buffer, register file, operand selects
`timescale 1ns/1ns
`include "rename_macros.svh"

module rename_commit_top import rename_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     flush_i,
    // Issue
    input  logic     issue_valid_i,
    input  reg_idx_t issue_rd_i,
    input  reg_idx_t issue_rs1_i,
    input  reg_idx_t issue_rs2_i,
    output logic     issue_ready_o,
    output rob_idx_t issue_rob_idx_o,
    // Source 1
    output logic     rs1_ready_o,
    output xlen_t    rs1_value_o,
    output rob_idx_t rs1_tag_o,
    // Source 2
    output logic     rs2_ready_o,
    output xlen_t    rs2_value_o,
    output rob_idx_t rs2_tag_o,
    // Writeback
    input  logic     wb_valid_i,
    input  rob_idx_t wb_rob_idx_i,
    input  xlen_t    wb_value_i,
    // Commit
    output logic     comm_valid_o,
    output reg_idx_t comm_rd_o,
    output xlen_t    comm_value_o
);

    // Accepted issue strobe from the buffer
    logic     issue_accept;
    rob_idx_t comm_head_idx;

    logic     rs1_busy;
    rob_idx_t rs1_owner;
    logic     rs2_busy;
    rob_idx_t rs2_owner;

    logic     rob_rs1_done;
    xlen_t    rob_rs1_value;
    logic     rob_rs2_done;
    xlen_t    rob_rs2_value;

    xlen_t    rf_rs1_value;
    xlen_t    rf_rs2_value;

    reg_status u_reg_status (
        .clk_i               (clk_i),
        .rst_n_i             (rst_n_i),
        .flush_i             (flush_i),
        .issue_valid_i       (issue_accept),
        .issue_rd_idx_i      (issue_rd_i),
        .issue_rob_idx_i     (issue_rob_idx_o),
        .issue_rs1_idx_i     (issue_rs1_i),
        .issue_rs2_idx_i     (issue_rs2_i),
        .comm_valid_i        (comm_valid_o),
        .comm_rd_idx_i       (comm_rd_o),
        .comm_head_idx_i     (comm_head_idx),
        .issue_rs1_busy_o    (rs1_busy),
        .issue_rs1_rob_idx_o (rs1_owner),
        .issue_rs2_busy_o    (rs2_busy),
        .issue_rs2_rob_idx_o (rs2_owner)
    );

    // Read ports indexed by the owning tags from the status table
    reorder_buffer u_reorder_buffer (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .flush_i         (flush_i),
        .alloc_valid_i   (issue_valid_i),
        .alloc_rd_i      (issue_rd_i),
        .alloc_ready_o   (issue_ready_o),
        .alloc_accept_o  (issue_accept),
        .alloc_idx_o     (issue_rob_idx_o),
        .wb_valid_i      (wb_valid_i),
        .wb_rob_idx_i    (wb_rob_idx_i),
        .wb_value_i      (wb_value_i),
        .rd1_tag_i       (rs1_owner),
        .rd2_tag_i       (rs2_owner),
        .rd1_done_o      (rob_rs1_done),
        .rd1_value_o     (rob_rs1_value),
        .rd2_done_o      (rob_rs2_done),
        .rd2_value_o     (rob_rs2_value),
        .comm_valid_o    (comm_valid_o),
        .comm_rd_o       (comm_rd_o),
        .comm_value_o    (comm_value_o),
        .comm_head_idx_o (comm_head_idx)
    );

    // Written by the committing head
    arch_regfile u_arch_regfile (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .wr_en_i    (comm_valid_o),
        .wr_idx_i   (comm_rd_o),
        .wr_data_i  (comm_value_o),
        .rd1_idx_i  (issue_rs1_i),
        .rd2_idx_i  (issue_rs2_i),
        .rd1_data_o (rf_rs1_value),
        .rd2_data_o (rf_rs2_value)
    );

    operand_select u_rs1_select (
        .busy_i      (rs1_busy),
        .tag_i       (rs1_owner),
        .rob_done_i  (rob_rs1_done),
        .rob_value_i (rob_rs1_value),
        .rf_value_i  (rf_rs1_value),
        .ready_o     (rs1_ready_o),
        .value_o     (rs1_value_o),
        .tag_o       (rs1_tag_o)
    );

    operand_select u_rs2_select (
        .busy_i      (rs2_busy),
        .tag_i       (rs2_owner),
        .rob_done_i  (rob_rs2_done),
        .rob_value_i (rob_rs2_value),
        .rf_value_i  (rf_rs2_value),
        .ready_o     (rs2_ready_o),
        .value_o     (rs2_value_o),
        .tag_o       (rs2_tag_o)
    );

endmodule

// File: logic/operand_select.sv
// Source operand resolution: register file value, reorder buffer value or pending tag
`timescale 1ns/1ns
`include "rename_macros.svh"

module operand_select import rename_pkg::*; (
    // From the status table
    input  logic     busy_i,
    input  rob_idx_t tag_i,
    // From the reorder buffer read port
    input  logic     rob_done_i,
    input  xlen_t    rob_value_i,
    // From the register file read port
    input  xlen_t    rf_value_i,
    // Resolved operand
    output logic     ready_o,
    output xlen_t    value_o,
    output rob_idx_t tag_o
);

    always_comb begin
        if (!busy_i) begin
            // Committed value
            ready_o = 1'b1;
            value_o = rf_value_i;
            tag_o   = '0;
        end else if (rob_done_i) begin
            // Produced but not yet committed
            ready_o = 1'b1;
            value_o = rob_value_i;
            tag_o   = '0;
        end else begin
            // Still in flight, consumer waits on this tag
            ready_o = 1'b0;
            value_o = '0;
            tag_o   = tag_i;
        end
    end

endmodule

// File: logic/arch_regfile.sv
// Architectural register file written at commit, two read ports, register zero reads zero
`timescale 1ns/1ns
`include "rename_macros.svh"

module arch_regfile import rename_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,
    // Commit write port
    input  logic     wr_en_i,
    input  reg_idx_t wr_idx_i,
    input  xlen_t    wr_data_i,
    // Source read ports
    input  reg_idx_t rd1_idx_i,
    input  reg_idx_t rd2_idx_i,
    output xlen_t    rd1_data_o,
    output xlen_t    rd2_data_o
);

    // No storage behind register zero
    xlen_t rf_q [1:`REG_NUM-1];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < `REG_NUM; i++) begin
                rf_q[i] <= '0;
            end
        end else if (wr_en_i && (wr_idx_i != '0)) begin
            // Writes to zero are dropped
            rf_q[wr_idx_i] <= wr_data_i;
        end
    end

    // Asynchronous reads
    assign rd1_data_o = (rd1_idx_i == '0) ? '0 : rf_q[rd1_idx_i];
    assign rd2_data_o = (rd2_idx_i == '0) ? '0 : rf_q[rd2_idx_i];

endmodule

// File: logic/reorder_buffer.sv
// Circular reorder buffer: tail allocation, writeback by tag, operand reads and in-order commit
`timescale 1ns/1ns
`include "rename_macros.svh"

module reorder_buffer import rename_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     flush_i,
    // Allocation request from issue
    input  logic     alloc_valid_i,
    input  reg_idx_t alloc_rd_i,
    output logic     alloc_ready_o,
    output logic     alloc_accept_o,
    output rob_idx_t alloc_idx_o,
    // Result from an execution unit
    input  logic     wb_valid_i,
    input  rob_idx_t wb_rob_idx_i,
    input  xlen_t    wb_value_i,
    // Two operand read ports, indexed by tag
    input  rob_idx_t rd1_tag_i,
    input  rob_idx_t rd2_tag_i,
    output logic     rd1_done_o,
    output xlen_t    rd1_value_o,
    output logic     rd2_done_o,
    output xlen_t    rd2_value_o,
    // Head commit
    output logic     comm_valid_o,
    output reg_idx_t comm_rd_o,
    output xlen_t    comm_value_o,
    output rob_idx_t comm_head_idx_o
);

    // Occupancy when every entry is taken
    localparam logic [`ROB_IDX_LEN:0] ROB_FULL = `ROB_DEPTH;

    rob_entry_t rob_q [`ROB_DEPTH];

    rob_idx_t head_q;
    rob_idx_t tail_q;
    // One bit wider than a tag to tell full from empty
    logic [`ROB_IDX_LEN:0] count_q;

    logic full;
    logic empty;
    logic do_alloc;
    logic do_commit;

    assign full  = count_q == ROB_FULL;
    assign empty = count_q == '0;

    // Issue is accepted whenever a free entry exists
    assign alloc_ready_o  = !full;
    assign do_alloc       = alloc_valid_i && !full;
    assign alloc_accept_o = do_alloc;
    assign alloc_idx_o    = tail_q;

    // Head leaves as soon as its result is in
    assign do_commit       = !empty && rob_q[head_q].done;
    assign comm_valid_o    = do_commit;
    assign comm_rd_o       = rob_q[head_q].rd;
    assign comm_value_o    = rob_q[head_q].value;
    assign comm_head_idx_o = head_q;

    // Pointers and occupancy
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (do_alloc) begin
                tail_q <= tail_q + 1'b1;
            end
            if (do_commit) begin
                head_q <= head_q + 1'b1;
            end
            // Allocate and commit together leave the count unchanged
            case ({do_alloc, do_commit})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Entry storage
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                rob_q[i] <= '0;
            end
        end else if (flush_i) begin
            // Stale done bits must not look like results later
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                rob_q[i].done <= 1'b0;
            end
        end else begin
            // Fresh entry waits for its result
            if (do_alloc) begin
                rob_q[tail_q].done  <= 1'b0;
                rob_q[tail_q].rd    <= alloc_rd_i;
                rob_q[tail_q].value <= '0;
            end
            // Writeback may target any allocated entry, in any order
            if (wb_valid_i) begin
                rob_q[wb_rob_idx_i].done  <= 1'b1;
                rob_q[wb_rob_idx_i].value <= wb_value_i;
            end
        end
    end

    // Operand reads, no bypass of a same-cycle writeback
    // The committing head still answers here until the edge
    assign rd1_done_o  = rob_q[rd1_tag_i].done;
    assign rd1_value_o = rob_q[rd1_tag_i].value;
    assign rd2_done_o  = rob_q[rd2_tag_i].done;
    assign rd2_value_o = rob_q[rd2_tag_i].value;

endmodule

// File: logic/reg_status.sv
// Register status table: busy bit and owning reorder buffer tag per architectural register
`timescale 1ns/1ns
`include "rename_macros.svh"

module reg_status import rename_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     flush_i,
    // Accepted issue, already qualified by the reorder buffer
    input  logic     issue_valid_i,
    input  reg_idx_t issue_rd_idx_i,
    input  rob_idx_t issue_rob_idx_i,
    input  reg_idx_t issue_rs1_idx_i,
    input  reg_idx_t issue_rs2_idx_i,
    // Commit of the reorder buffer head
    input  logic     comm_valid_i,
    input  reg_idx_t comm_rd_idx_i,
    input  rob_idx_t comm_head_idx_i,
    // Source lookups for the issuing instruction
    output logic     issue_rs1_busy_o,
    output rob_idx_t issue_rs1_rob_idx_o,
    output logic     issue_rs2_busy_o,
    output rob_idx_t issue_rs2_rob_idx_o
);

    regstat_entry_t regstat_q [`REG_NUM];

    // Issue marks rd busy, except for the zero register
    logic issue_set;
    // Commit frees rd only when the head is still its last writer
    logic comm_match;
    logic comm_clr;

    assign issue_set  = issue_valid_i && (issue_rd_idx_i != '0);
    assign comm_match = regstat_q[comm_rd_idx_i].rob_idx == comm_head_idx_i;
    // A same-cycle issue to the same register keeps it busy
    assign comm_clr   = comm_valid_i && comm_match &&
                        !(issue_set && (issue_rd_idx_i == comm_rd_idx_i));

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regstat_q[i] <= '0;
            end
        end else if (flush_i) begin
            // Everything in flight is gone, values come from the register file again
            for (int i = 0; i < `REG_NUM; i++) begin
                regstat_q[i] <= '0;
            end
        end else begin
            if (comm_clr) begin
                regstat_q[comm_rd_idx_i].busy <= 1'b0;
            end
            // New owner of rd is the tail entry
            if (issue_set) begin
                regstat_q[issue_rd_idx_i].busy    <= 1'b1;
                regstat_q[issue_rd_idx_i].rob_idx <= issue_rob_idx_i;
            end
        end
    end

    // Read ports see the table before the edge
    // so rs equal to rd returns the previous owner
    assign issue_rs1_busy_o    = regstat_q[issue_rs1_idx_i].busy;
    assign issue_rs1_rob_idx_o = regstat_q[issue_rs1_idx_i].rob_idx;
    assign issue_rs2_busy_o    = regstat_q[issue_rs2_idx_i].busy;
    assign issue_rs2_rob_idx_o = regstat_q[issue_rs2_idx_i].rob_idx;

endmodule

// File: logic/rename_pkg.sv
// Shared types for the rename and commit blocks, imported by every RTL module
`include "rename_macros.svh"

package rename_pkg;

    // Architectural register index
    typedef logic [`REG_IDX_LEN-1:0] reg_idx_t;

    // Reorder buffer tag, also the entry index
    typedef logic [`ROB_IDX_LEN-1:0] rob_idx_t;

    // Integer data word
    typedef logic [`XLEN-1:0] xlen_t;

    // Register status table entry
    // busy set while an in-flight instruction owns the register
    typedef struct packed {
        logic     busy;
        rob_idx_t rob_idx;
    } regstat_entry_t;

    // Reorder buffer entry
    // done set once the result has been written back
    typedef struct packed {
        logic     done;
        reg_idx_t rd;
        xlen_t    value;
    } rob_entry_t;

endpackage

// File: logic/rename_macros.svh
// Size constants for the rename and commit subsystem, included by the package and all RTL
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// Architectural register file
`define REG_NUM 32
// Must hold REG_NUM-1
`define REG_IDX_LEN 5

// Width of every integer result
`define XLEN 32

// Reorder buffer entries
`define ROB_DEPTH 8
// Tag width, log2 of ROB_DEPTH
// Pointers wrap by plain overflow, so depth stays a power of two
`define ROB_IDX_LEN 3

`endif
